// File: Makefile
TOP := discrete_int_tb
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f discrete_link.f --top-module $(TOP)

run: compile
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: design/discrete_int.sv
`timescale 1ns/1ps
`include "link_defs.svh"

module discrete_int (
	input  logic       clk,
	input  logic       reset,

	input  logic       scl_discrete_buf,
	output logic       scl_pd,
	output logic       scl_pu,
	output logic       scl_tri,

	input  logic       sda_discrete_buf,
	output logic       sda_pd,
	output logic       sda_pu,
	output logic       sda_tri,

	input  logic [7:0] tx_char,
	input  logic       tx_char_latch,
	input  logic       tx_req,

	output logic [7:0] rx_char,
	output logic       rx_char_latch,
	output logic       rx_req
);

	link_pkg::tx_entry_t push_entry;
	link_pkg::tx_entry_t head;
	logic                push;
	logic                head_valid;
	logic                pop;
	logic                rx_busy;
	logic                scl_up;
	logic                scl_down;
	logic                sda_up;
	logic                sda_down;

	// A frame request is queued as a marker behind the bytes of its frame
	always_comb begin
		push_entry.marker = tx_req;
		push_entry.data = tx_char;
	end

	assign push = tx_char_latch | tx_req;

	link_fifo #(
		.ADDR_BITS(`LINK_FIFO_DEPTH_LOG2)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.in(push_entry),
		.in_latch(push),
		.out(head),
		.out_latch(pop),
		.out_valid(head_valid)
	);

	link_tx u_tx (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.head(head),
		.head_valid(head_valid),
		.rx_busy(rx_busy),
		.pop(pop),
		.scl_up(scl_up),
		.scl_down(scl_down),
		.sda_up(sda_up),
		.sda_down(sda_down)
	);

	link_rx u_rx (
		.clk(clk),
		.reset(reset),
		.scl_line(scl_discrete_buf),
		.sda_line(sda_discrete_buf),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req),
		.rx_busy(rx_busy)
	);

	// Pull-up enables are active low at the pads
	assign scl_pd = scl_down;
	assign scl_pu = ~scl_up;
	assign scl_tri = scl_up | scl_down;

	assign sda_pd = sda_down;
	assign sda_pu = ~sda_up;
	assign sda_tri = sda_up | sda_down;

endmodule

// File: design/link_defs.svh
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// Terminal count of the phase counter. A bus phase lasts this many clocks plus one
`define LINK_CLOCK_DIV 25

// Transmit queue depth as a power of two
`define LINK_FIFO_DEPTH_LOG2 4

`endif

// File: design/link_fifo.sv
`timescale 1ns/1ps

module link_fifo #(
	parameter int ADDR_BITS = 4
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [$bits(link_pkg::tx_entry_t)-1:0] in,
	input  logic                                  in_latch,
	output logic [$bits(link_pkg::tx_entry_t)-1:0] out,
	input  logic                                  out_latch,
	output logic                                  out_valid
);

	localparam int WIDTH = $bits(link_pkg::tx_entry_t);
	localparam int DEPTH = 1 << ADDR_BITS;

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0]   count;
	logic                 full;
	logic                 push;
	logic                 pop;

	// Count reaches DEPTH exactly when its top bit is set
	assign full = count[ADDR_BITS];
	assign out_valid = (count != '0);
	assign push = in_latch && !full;
	assign pop = out_latch && out_valid;
	assign out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: design/link_pkg.sv
package link_pkg;

	// A transmit queue entry holds a character or a frame-end marker
	typedef struct packed {
		logic       marker;
		logic [7:0] data;
	} tx_entry_t;

	typedef enum logic [3:0] {
		TX_IDLE     = 4'd0,
		TX_START    = 4'd1,
		TX_BIT_LOW  = 4'd2,
		TX_BIT_HIGH = 4'd3,
		TX_ACK_LOW  = 4'd4,
		TX_ACK_HIGH = 4'd5,
		TX_STOP0    = 4'd6,
		TX_STOP1    = 4'd7,
		TX_STOP2    = 4'd8
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE = 2'd0,
		RX_DATA = 2'd1,
		RX_ACK  = 2'd2
	} rx_state_t;

endpackage

// File: design/link_rx.sv
`timescale 1ns/1ps

module link_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       scl_line,
	input  logic       sda_line,
	output logic [7:0] rx_char,
	output logic       rx_char_latch,
	output logic       rx_req,
	output logic       rx_busy
);

	link_pkg::rx_state_t state;
	link_pkg::rx_state_t next_state;

	logic       scl_meta;
	logic       scl_sync;
	logic       scl_last;
	logic       sda_meta;
	logic       sda_sync;
	logic       sda_last;
	logic       scl_rise;
	logic       scl_fall;
	logic       stop_seen;
	logic [6:0] shift_reg;
	logic       shift_en;
	logic [2:0] edge_cnt;
	logic       cnt_step;
	logic       cnt_clear;

	assign scl_rise = scl_sync && !scl_last;
	assign scl_fall = !scl_sync && scl_last;
	assign stop_seen = sda_sync && !sda_last && scl_sync;

	// The last bit is taken straight from the line so the byte is whole during the strobe
	assign rx_char = {shift_reg, sda_sync};

	always_comb begin
		next_state = state;
		rx_char_latch = 1'b0;
		rx_req = 1'b0;
		shift_en = 1'b0;
		cnt_step = 1'b0;
		cnt_clear = 1'b0;

		case (state)
			link_pkg::RX_IDLE: begin
				cnt_clear = 1'b1;
				if (!sda_sync) begin
					next_state = link_pkg::RX_DATA;
				end
			end

			// A stop lands here after the sender's last SCL fall
			link_pkg::RX_DATA: begin
				if (stop_seen) begin
					rx_req = 1'b1;
					next_state = link_pkg::RX_IDLE;
				end else if (scl_rise) begin
					shift_en = 1'b1;
					cnt_step = 1'b1;
					if (edge_cnt == 3'd7) begin
						cnt_clear = 1'b1;
						rx_char_latch = 1'b1;
						next_state = link_pkg::RX_ACK;
					end
				end
			end

			link_pkg::RX_ACK: begin
				if (stop_seen) begin
					rx_req = 1'b1;
					next_state = link_pkg::RX_IDLE;
				end else if (scl_fall) begin
					cnt_step = 1'b1;
					if (edge_cnt == 3'd1) begin
						cnt_clear = 1'b1;
						next_state = link_pkg::RX_DATA;
					end
				end
			end

			default: begin
				next_state = link_pkg::RX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (shift_en) begin
			shift_reg <= {shift_reg[5:0], sda_sync};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= link_pkg::RX_IDLE;
			rx_busy <= 1'b0;
			edge_cnt <= '0;
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			scl_last <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
			sda_last <= 1'b1;
		end else begin
			state <= next_state;
			rx_busy <= (next_state != link_pkg::RX_IDLE);

			if (cnt_clear) begin
				edge_cnt <= '0;
			end else if (cnt_step) begin
				edge_cnt <= edge_cnt + 1'b1;
			end

			scl_meta <= scl_line;
			scl_sync <= scl_meta;
			scl_last <= scl_sync;
			sda_meta <= sda_line;
			sda_sync <= sda_meta;
			sda_last <= sda_sync;
		end
	end

endmodule

// File: design/link_tx.sv
`timescale 1ns/1ps
`include "link_defs.svh"

module link_tx (
	input  logic                clk,
	input  logic                reset,
	input  logic                tx_req,
	input  link_pkg::tx_entry_t head,
	input  logic                head_valid,
	input  logic                rx_busy,
	output logic                pop,
	output logic                scl_up,
	output logic                scl_down,
	output logic                sda_up,
	output logic                sda_down
);

	localparam int CNT_BITS = $clog2(`LINK_CLOCK_DIV + 2);
	localparam logic [CNT_BITS-1:0] PHASE_END = CNT_BITS'(`LINK_CLOCK_DIV);

	link_pkg::tx_state_t state;
	link_pkg::tx_state_t next_state;

	logic [CNT_BITS-1:0] phase_cnt;
	logic                phase_done;
	logic [2:0]          bit_idx;
	logic                bit_load;
	logic                bit_step;
	logic                req_flag;
	logic                req_clear;
	logic                byte_next;
	logic                scl_drive;
	logic                scl_val;
	logic                sda_drive;
	logic                sda_val;

	assign phase_done = (phase_cnt == PHASE_END);

	// Another byte follows only while the head holds a character
	assign byte_next = head_valid && !head.marker;

	always_comb begin
		next_state = state;
		pop = 1'b0;
		req_clear = 1'b0;
		bit_load = 1'b0;
		bit_step = 1'b0;
		scl_drive = 1'b0;
		scl_val = 1'b1;
		sda_drive = 1'b0;
		sda_val = 1'b1;

		case (state)
			link_pkg::TX_IDLE: begin
				if (req_flag && !rx_busy) begin
					next_state = link_pkg::TX_START;
				end
			end

			// SDA falls while SCL is held high
			link_pkg::TX_START: begin
				req_clear = 1'b1;
				bit_load = 1'b1;
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_val = 1'b0;
				if (phase_done) begin
					next_state = link_pkg::TX_BIT_LOW;
				end
			end

			link_pkg::TX_BIT_LOW: begin
				scl_drive = 1'b1;
				scl_val = 1'b0;
				sda_drive = 1'b1;
				sda_val = head.data[bit_idx];
				if (phase_done) begin
					next_state = link_pkg::TX_BIT_HIGH;
				end
			end

			link_pkg::TX_BIT_HIGH: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_val = head.data[bit_idx];
				if (phase_done) begin
					bit_step = 1'b1;
					if (bit_idx == 3'd0) begin
						next_state = link_pkg::TX_ACK_LOW;
					end else begin
						next_state = link_pkg::TX_BIT_LOW;
					end
				end
			end

			// SDA stays released for the whole acknowledge slot
			link_pkg::TX_ACK_LOW: begin
				scl_drive = 1'b1;
				scl_val = 1'b0;
				if (phase_done) begin
					pop = 1'b1;
					next_state = link_pkg::TX_ACK_HIGH;
				end
			end

			link_pkg::TX_ACK_HIGH: begin
				scl_drive = 1'b1;
				bit_load = 1'b1;
				if (phase_done) begin
					if (byte_next) begin
						next_state = link_pkg::TX_BIT_LOW;
					end else begin
						next_state = link_pkg::TX_STOP0;
					end
				end
			end

			link_pkg::TX_STOP0: begin
				scl_drive = 1'b1;
				scl_val = 1'b0;
				sda_drive = 1'b1;
				sda_val = 1'b0;
				if (phase_done) begin
					next_state = link_pkg::TX_STOP1;
				end
			end

			link_pkg::TX_STOP1: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_val = 1'b0;
				if (phase_done) begin
					next_state = link_pkg::TX_STOP2;
				end
			end

			// The release on the way to idle lets SDA rise with SCL high
			link_pkg::TX_STOP2: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_val = 1'b0;
				if (phase_done) begin
					pop = 1'b1;
					next_state = link_pkg::TX_IDLE;
				end
			end

			default: begin
				next_state = link_pkg::TX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= link_pkg::TX_IDLE;
			phase_cnt <= '0;
			bit_idx <= 3'd7;
			req_flag <= 1'b0;
			scl_up <= 1'b0;
			scl_down <= 1'b0;
			sda_up <= 1'b0;
			sda_down <= 1'b0;
		end else begin
			state <= next_state;

			if (next_state != state || state == link_pkg::TX_IDLE) begin
				phase_cnt <= '0;
			end else begin
				phase_cnt <= phase_cnt + 1'b1;
			end

			if (bit_load) begin
				bit_idx <= 3'd7;
			end else if (bit_step) begin
				bit_idx <= bit_idx - 1'b1;
			end

			// A new request in the clearing cycle still counts
			req_flag <= (req_flag && !req_clear) || tx_req;

			scl_up <= scl_drive && scl_val;
			scl_down <= scl_drive && !scl_val;
			sda_up <= sda_drive && sda_val;
			sda_down <= sda_drive && !sda_val;
		end
	end

endmodule

// File: discrete_link.f
+incdir+design
design/link_pkg.sv
design/link_fifo.sv
design/link_tx.sv
design/link_rx.sv
design/discrete_int.sv
testbench/link_props.sv
testbench/discrete_int_tb.sv

// File: testbench/discrete_int_tb.sv
`timescale 1ns/1ps
`include "link_defs.svh"

module discrete_int_tb;

	localparam int PHASE_CLOCKS = `LINK_CLOCK_DIV + 1;
	localparam int MAX_BYTES = 8;
	localparam int MAX_PHASES = 2 + 2 * 9 * MAX_BYTES + 3;
	localparam int LOOP_FRAMES = 12;
	localparam int BUS_FRAMES = 6;
	localparam int DEFER_FRAMES = 3;
	localparam int TOTAL_FRAMES = LOOP_FRAMES + BUS_FRAMES + 2 * DEFER_FRAMES;
	localparam int FRAME_LIMIT = MAX_PHASES * PHASE_CLOCKS + 200;
	localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_LIMIT + 1000;
	localparam int FRAME_END = 256;

	logic       clk;
	logic       reset;
	logic [7:0] tx_char;
	logic       tx_char_latch;
	logic       tx_req;
	logic       tb_scl_low;
	logic       tb_sda_low;
	logic       scl_line;
	logic       sda_line;
	logic       scl_pd;
	logic       scl_pu;
	logic       scl_tri;
	logic       sda_pd;
	logic       sda_pu;
	logic       sda_tri;
	logic [7:0] rx_char;
	logic       rx_char_latch;
	logic       rx_req;

	logic [31:0] lfsr;
	logic        requested;
	int          expected [$];
	int          check_errors;
	int          flow_errors;
	int          props_failures;
	int          total_errors;
	int          bytes_seen;
	int          frames_seen;
	int          frames_sent;
	int          hold_until;

	// Each line has a pull-up and goes low when either side pulls it down
	assign scl_line = !scl_pd && !tb_scl_low;
	assign sda_line = !sda_pd && !tb_sda_low;

	discrete_int DUT (
		.clk(clk),
		.reset(reset),
		.scl_discrete_buf(scl_line),
		.scl_pd(scl_pd),
		.scl_pu(scl_pu),
		.scl_tri(scl_tri),
		.sda_discrete_buf(sda_line),
		.sda_pd(sda_pd),
		.sda_pu(sda_pu),
		.sda_tri(sda_tri),
		.tx_char(tx_char),
		.tx_char_latch(tx_char_latch),
		.tx_req(tx_req),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | {31'd0, lfsr[0]};
		end
		return v;
	endfunction

	task automatic push_byte(input logic [7:0] value);
		@(posedge clk);
		tx_char <= value;
		tx_char_latch <= 1'b1;
		@(posedge clk);
		tx_char_latch <= 1'b0;
	endtask

	task automatic queue_frame(input int count);
		logic [7:0] value;
		for (int i = 0; i < count; i++) begin
			value = 8'(rand_bits(8));
			expected.push_back(int'(value));
			push_byte(value);
		end
		expected.push_back(FRAME_END);
		@(posedge clk);
		tx_req <= 1'b1;
		requested = 1'b1;
		@(posedge clk);
		tx_req <= 1'b0;
	endtask

	task automatic bus_phase(input logic scl_low, input logic sda_low, input int clocks);
		@(posedge clk);
		tb_scl_low <= scl_low;
		tb_sda_low <= sda_low;
		repeat (clocks - 1) @(posedge clk);
	endtask

	// With defer set, a DUT frame is queued after the first byte of this one
	task automatic drive_bus_frame(input int count, input int clocks, input bit defer);
		logic [7:0] data [$];
		logic [7:0] value;
		for (int i = 0; i < count; i++) begin
			value = 8'(rand_bits(8));
			data.push_back(value);
			expected.push_back(int'(value));
		end
		expected.push_back(FRAME_END);
		hold_until = frames_sent + 1;
		bus_phase(1'b0, 1'b1, clocks);
		for (int i = 0; i < count; i++) begin
			for (int k = 7; k >= 0; k--) begin
				bus_phase(1'b1, !data[i][k], clocks);
				bus_phase(1'b0, !data[i][k], clocks);
			end
			bus_phase(1'b1, 1'b0, clocks);
			bus_phase(1'b0, 1'b0, clocks);
			if (defer && i == 0) begin
				queue_frame(1 + int'(rand_bits(3)));
			end
		end
		bus_phase(1'b1, 1'b1, clocks);
		bus_phase(1'b0, 1'b1, clocks);
		bus_phase(1'b0, 1'b0, clocks);
	endtask

	task automatic wait_frames(input int target);
		int waited;
		waited = 0;
		while (frames_seen < target && waited < FRAME_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (frames_seen >= target) else begin
			flow_errors++;
			$display("Frame end %0d did not arrive within %0d clocks", target, FRAME_LIMIT);
		end
	endtask

	task automatic check_byte(input logic [7:0] value);
		int want;
		bytes_seen++;
		assert (expected.size() != 0) else begin
			check_errors++;
			$display("Byte %02h received at %0t with nothing expected", value, $time);
		end
		if (expected.size() != 0) begin
			want = expected.pop_front();
			assert (want != FRAME_END) else begin
				check_errors++;
				$display("Byte %02h received at %0t where a frame end was due", value, $time);
			end
			assert (want == FRAME_END || want == int'(value)) else begin
				check_errors++;
				$display("FAILED at %0t: rx_char = %02h, expected %02h", $time, value, want[7:0]);
			end
		end
	endtask

	task automatic check_frame_end();
		int want;
		frames_seen++;
		assert (expected.size() != 0) else begin
			check_errors++;
			$display("rx_req arrived at %0t with no frame end expected", $time);
		end
		if (expected.size() != 0) begin
			want = expected.pop_front();
			assert (want == FRAME_END) else begin
				check_errors++;
				$display("rx_req arrived at %0t before the frame's bytes were all received",
					$time);
			end
		end
	endtask

	task automatic check_pads();
		assert (scl_tri == (scl_pd | ~scl_pu)) else begin
			check_errors++;
			$display("FAILED at %0t: scl_tri = %b, expected %b", $time, scl_tri,
				scl_pd | ~scl_pu);
		end
		assert (sda_tri == (sda_pd | ~sda_pu)) else begin
			check_errors++;
			$display("FAILED at %0t: sda_tri = %b, expected %b", $time, sda_tri,
				sda_pd | ~sda_pu);
		end
		assert (!(scl_pd && !scl_pu) && !(sda_pd && !sda_pu)) else begin
			check_errors++;
			$display("A line is pulled up and down at once at %0t", $time);
		end
		if (!requested) begin
			assert ({scl_pd, scl_pu, scl_tri, sda_pd, sda_pu, sda_tri} == 6'b010010) else begin
				check_errors++;
				$display("FAILED at %0t: pads = %b, expected 010010", $time,
					{scl_pd, scl_pu, scl_tri, sda_pd, sda_pu, sda_tri});
			end
		end
		if (frames_seen < hold_until) begin
			assert (!sda_pd) else begin
				check_errors++;
				$display("sda_pd rose at %0t while a testbench frame was in progress", $time);
			end
		end
	endtask

	// DUT outputs are checked on every falling edge
	always @(negedge clk) begin
		if (!reset) begin
			check_pads();
			if (rx_char_latch) begin
				check_byte(rx_char);
			end
			if (rx_req) begin
				check_frame_end();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d clocks before the tests finished", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		tx_char = 8'h00;
		tx_char_latch = 1'b0;
		tx_req = 1'b0;
		tb_scl_low = 1'b0;
		tb_sda_low = 1'b0;
		lfsr = 32'hc15e;
		requested = 1'b0;
		check_errors = 0;
		flow_errors = 0;
		bytes_seen = 0;
		frames_seen = 0;
		frames_sent = 0;
		hold_until = 0;
		assert (MAX_BYTES < (1 << `LINK_FIFO_DEPTH_LOG2)) else begin
			flow_errors++;
			$display("The largest frame does not fit the transmit FIFO");
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		for (int f = 0; f < LOOP_FRAMES; f++) begin
			queue_frame(1 + int'(rand_bits(3)));
			frames_sent++;
			wait_frames(frames_sent);
		end

		for (int f = 0; f < BUS_FRAMES; f++) begin
			drive_bus_frame(1 + int'(rand_bits(3)), 3 + int'(rand_bits(3)), 1'b0);
			frames_sent++;
			wait_frames(frames_sent);
		end

		for (int f = 0; f < DEFER_FRAMES; f++) begin
			drive_bus_frame(1 + int'(rand_bits(3)), 3 + int'(rand_bits(3)), 1'b1);
			frames_sent += 2;
			wait_frames(frames_sent - 1);
			wait_frames(frames_sent);
		end

		repeat (10) @(posedge clk);
		assert (expected.size() == 0) else begin
			flow_errors++;
			$display("%0d expected bytes or frame ends never arrived", expected.size());
		end
		props_failures = int'(DUT.u_tx.u_props.fail_count);
		total_errors = check_errors + flow_errors + props_failures;
		$display("Errors: %0d (checks %0d, flow %0d, assertions %0d), bytes %0d, frames %0d",
			total_errors, check_errors, flow_errors, props_failures, bytes_seen, frames_seen);
		if (total_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/link_props.sv
`timescale 1ns/1ps

module link_props (
	input logic                clk,
	input logic                reset,
	input link_pkg::tx_state_t state,
	input logic                scl_up,
	input logic                scl_down,
	input logic                sda_up,
	input logic                sda_down
);

	int unsigned fail_count = 0;

	a_scl_drive: assert property (@(posedge clk) disable iff (reset) !(scl_up && scl_down))
		else begin
			$error("scl_up and scl_down are both high");
			fail_count++;
		end

	a_sda_drive: assert property (@(posedge clk) disable iff (reset) !(sda_up && sda_down))
		else begin
			$error("sda_up and sda_down are both high");
			fail_count++;
		end

	// Pads follow the state by one clock, so an idle state shows on the next edge
	a_idle_released: assert property (@(posedge clk) disable iff (reset)
		state == link_pkg::TX_IDLE |=> !(scl_up || scl_down || sda_up || sda_down))
		else begin
			$error("A line is still driven while the transmitter is idle");
			fail_count++;
		end

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state <= link_pkg::TX_STOP2)
		else begin
			$error("Transmit state left the enumeration");
			fail_count++;
		end

endmodule

bind link_tx link_props u_props (
	.clk(clk),
	.reset(reset),
	.state(state),
	.scl_up(scl_up),
	.scl_down(scl_down),
	.sda_up(sda_up),
	.sda_down(sda_down)
);
